// File: design/button_pkg.sv
// Shared constants and types for the two-button step counter.
// Imported by the debouncer, the hold timer and the step counter.
`default_nettype none

package button_pkg;

   // the lockout after an accepted press lasts 2 us at 25 MHz.
   localparam int unsigned HOLD_CYCLES = 50;

   // The hold timer counts up to HOLD_CYCLES, so it needs 6 bits.
   localparam int unsigned HOLD_WIDTH = 6;

   // step count width and the ceiling where it saturates.
   localparam int unsigned COUNT_WIDTH = 8;
   localparam int unsigned COUNT_MAX = 255;

   // The consumer grants this many credits at reset.
   localparam int unsigned CREDIT_MAX = 4;

   // Holds the values 0 to CREDIT_MAX.
   localparam int unsigned CREDIT_WIDTH = 3;

   // debouncer FSM states.
   // The encoding keeps a single bit change on most transitions.
   typedef enum logic [1:0] {
      IDLE         = 2'b00,
      PRESSED      = 2'b01,
      LOCKOUT      = 2'b11,
      WAIT_RELEASE = 2'b10
   } debounce_state_t;

   // opcode carried by every step event.
   typedef enum logic {
      STEP_UP   = 1'b0,
      STEP_DOWN = 1'b1
   } step_op_t;

endpackage : button_pkg

`default_nettype wire

// File: design/hold_timer.sv
// Restartable lockout timer for one debouncer.
// A restart strobe clears it, and o_expired rises once HOLD_CYCLES have passed.
`timescale 1ns/10ps
`default_nettype none

module hold_timer (
   input  logic i_clk_25MHz,
   input  logic i_reset,
   input  logic i_restart,
   output logic o_expired
);

   import button_pkg::*;

   logic [HOLD_WIDTH-1:0] count_q;

   // The counter stops at the limit and stays there until the next restart,
   // so the expired flag stays high while the debouncer waits on the
   // release.
   always_ff @(posedge i_clk_25MHz) begin
      if (i_reset) begin
         count_q <= '0;
      end
      else if (i_restart) begin
         count_q <= '0;
      end
      else if (!o_expired) begin
         count_q <= count_q + 1'b1;
      end
   end

   // expired is decoded straight from the counter.
   assign o_expired = (count_q == HOLD_WIDTH'(HOLD_CYCLES));

endmodule : hold_timer

`default_nettype wire

// File: design/edge_debouncer.sv
// Edge debouncer for one push button.
// Gives one single-cycle press pulse for each physical press.
`timescale 1ns/10ps
`default_nettype none

module edge_debouncer (
   input  logic i_clk_25MHz,
   input  logic i_reset,
   input  logic i_button,
   output logic o_press
);

   import button_pkg::*;

   logic            btn_meta_q;
   logic            btn_sync_q;
   logic            timer_restart;
   logic            timer_expired;
   debounce_state_t state_q;
   debounce_state_t state_d;

   // Two flops bring the raw contact into the clock domain.
   always_ff @(posedge i_clk_25MHz) begin
      if (i_reset) begin
         btn_meta_q <= 1'b0;
         btn_sync_q <= 1'b0;
      end
      else begin
         btn_meta_q <= i_button;
         btn_sync_q <= btn_meta_q;
      end
   end

   always_ff @(posedge i_clk_25MHz) begin
      if (i_reset) begin
         state_q <= IDLE;
      end
      else begin
         state_q <= state_d;
      end
   end

   // IDLE waits for a high level, and PRESSED lasts a single cycle.
   // LOCKOUT ignores the input until the timer runs out. A button that is
   // still held then waits in WAIT_RELEASE.
   always_comb begin
      state_d = state_q;
      case (state_q)
         IDLE: begin
            if (btn_sync_q) begin
               state_d = PRESSED;
            end
         end
         PRESSED: begin
            state_d = LOCKOUT;
         end
         LOCKOUT: begin
            if (timer_expired) begin
               if (btn_sync_q) begin
                  state_d = WAIT_RELEASE;
               end
               else begin
                  state_d = IDLE;
               end
            end
         end
         WAIT_RELEASE: begin
            if (!btn_sync_q) begin
               state_d = IDLE;
            end
         end
         default: begin
            state_d = IDLE;
         end
      endcase
   end

   // the pulse and the timer restart share the PRESSED cycle.
   assign o_press       = (state_q == PRESSED);
   assign timer_restart = (state_q == PRESSED);

   hold_timer hold_timer_i (
      .i_clk_25MHz (i_clk_25MHz),
      .i_reset     (i_reset),
      .i_restart   (timer_restart),
      .o_expired   (timer_expired)
   );

endmodule : edge_debouncer

`default_nettype wire

// File: design/step_counter.sv
// Turns up and down press pulses into a saturating count.
// Sends one event per accepted step to a consumer under credit control.
`timescale 1ns/10ps
`default_nettype none

module step_counter (
   input  logic                               i_clk_25MHz,
   input  logic                               i_reset,
   input  logic                               i_up_press,
   input  logic                               i_down_press,
   input  logic                               i_credit,
   output logic                               o_evt_valid,
   output button_pkg::step_op_t               o_evt_op,
   output logic [button_pkg::COUNT_WIDTH-1:0] o_evt_count
);

   import button_pkg::*;

   logic [COUNT_WIDTH-1:0]  count_q;
   logic [COUNT_WIDTH-1:0]  count_d;
   logic [CREDIT_WIDTH-1:0] credits;
   logic                    have_credit;
   logic                    up_only;
   logic                    down_only;
   logic                    accept_up;
   logic                    accept_down;
   logic                    accept;
   logic                    evt_valid_q;
   step_op_t                evt_op_q;

   // presses in the same cycle cancel each other.
   assign up_only   = i_up_press & ~i_down_press;
   assign down_only = i_down_press & ~i_up_press;

   assign have_credit = (credits != '0);

   // A step is accepted only if it has a credit and stays inside 0 to
   // COUNT_MAX. A rejected step is simply dropped.
   assign accept_up   = up_only & have_credit &
                        (count_q != COUNT_WIDTH'(COUNT_MAX));
   assign accept_down = down_only & have_credit & (count_q != '0);
   assign accept      = accept_up | accept_down;

   always_comb begin
      count_d = count_q;
      if (accept_up) begin
         count_d = count_q + 1'b1;
      end
      else if (accept_down) begin
         count_d = count_q - 1'b1;
      end
   end

   always_ff @(posedge i_clk_25MHz) begin
      if (i_reset) begin
         count_q <= '0;
      end
      else begin
         count_q <= count_d;
      end
   end

   // Credit bookkeeping.
   // A spend and a return in the same cycle leave the counter unchanged.
   always_ff @(posedge i_clk_25MHz) begin
      if (i_reset) begin
         credits <= CREDIT_WIDTH'(CREDIT_MAX);
      end
      else begin
         case ({accept, i_credit})
            2'b10: begin
               credits <= credits - 1'b1;
            end
            2'b01: begin
               credits <= credits + 1'b1;
            end
            default: begin
               credits <= credits;
            end
         endcase
      end
   end

   // The valid strobe is registered, so it follows the press pulse by one
   // cycle and is high for only that cycle.
   always_ff @(posedge i_clk_25MHz) begin
      if (i_reset) begin
         evt_valid_q <= 1'b0;
      end
      else begin
         evt_valid_q <= accept;
      end
   end

   // the opcode payload is loaded only for an accepted step.
   always_ff @(posedge i_clk_25MHz) begin
      if (accept) begin
         evt_op_q <= accept_down ? STEP_DOWN : STEP_UP;
      end
   end

   assign o_evt_valid = evt_valid_q;
   assign o_evt_op    = evt_op_q;

   // The count register takes its new value on the same edge as the
   // strobe, so it already holds the count that belongs to the event.
   assign o_evt_count = count_q;

endmodule : step_counter

`default_nettype wire

// File: design/button_panel_top.sv
// Top level of the button panel.
// Two debounced buttons drive one credit-controlled step counter.
`timescale 1ns/10ps
`default_nettype none

module button_panel_top (
   input  logic                               i_clk_25MHz,
   input  logic                               i_reset,
   input  logic                               i_btn_up,
   input  logic                               i_btn_down,
   input  logic                               i_credit,
   output logic                               o_evt_valid,
   output button_pkg::step_op_t               o_evt_op,
   output logic [button_pkg::COUNT_WIDTH-1:0] o_evt_count
);

   // Single-cycle press pulses from the debouncers.
   logic up_press;
   logic down_press;

   // The two buttons run side by side, each with its own lockout timer.
   edge_debouncer up_deb (
      .i_clk_25MHz (i_clk_25MHz),
      .i_reset     (i_reset),
      .i_button    (i_btn_up),
      .o_press     (up_press)
   );

   edge_debouncer down_deb (
      .i_clk_25MHz (i_clk_25MHz),
      .i_reset     (i_reset),
      .i_button    (i_btn_down),
      .o_press     (down_press)
   );

   // A clean raw edge gives an event four cycles later: two synchronizer
   // flops, the PRESSED state and the registered event.
   step_counter step_counter_i (
      .i_clk_25MHz  (i_clk_25MHz),
      .i_reset      (i_reset),
      .i_up_press   (up_press),
      .i_down_press (down_press),
      .i_credit     (i_credit),
      .o_evt_valid  (o_evt_valid),
      .o_evt_op     (o_evt_op),
      .o_evt_count  (o_evt_count)
   );

endmodule : button_panel_top

`default_nettype wire

// File: testbench/clock_gen.sv
// Testbench clock and reset source.
// Makes the 40 ns clock and holds reset high for the first two rising edges.
`timescale 1ns/10ps
`default_nettype none

module clock_gen (
   output logic o_clk_25MHz,
   output logic o_reset
);

   // the clock runs at 25 MHz, so half a period is 20 ns.
   initial begin
      o_clk_25MHz = 1'b0;
      forever #20 o_clk_25MHz = ~o_clk_25MHz;
   end

   // reset drops a short time after the second rising edge, like any other input.
   initial begin
      o_reset = 1'b1;
      repeat (2) @(posedge o_clk_25MHz);
      #2;
      o_reset = 1'b0;
   end

endmodule : clock_gen

`default_nettype wire

// File: testbench/button_panel_props.sv
// Protocol properties for the step counter's credit channel.
// Bound into step_counter by the testbench.
`timescale 1ns/10ps
`default_nettype none

module button_panel_props (
   input logic                                i_clk_25MHz,
   input logic                                i_reset,
   input logic                                i_evt_valid,
   input logic [button_pkg::CREDIT_WIDTH-1:0] i_credits
);

   import button_pkg::*;

   // number of properties that have failed so far.
   int unsigned fail_count = 0;

   // The strobe is registered, so the credit it spent was held one cycle earlier.
   evt_needs_credit: assert property (
      @(posedge i_clk_25MHz) disable iff (i_reset)
      i_evt_valid |-> ($past(i_credits) != '0)
   ) else begin
      $error("event sent without a credit");
      fail_count++;
   end

   credits_bounded: assert property (
      @(posedge i_clk_25MHz) disable iff (i_reset)
      i_credits <= CREDIT_WIDTH'(CREDIT_MAX)
   ) else begin
      $error("credit counter above its reset value");
      fail_count++;
   end

   evt_single_cycle: assert property (
      @(posedge i_clk_25MHz) disable iff (i_reset)
      i_evt_valid |=> !i_evt_valid
   ) else begin
      $error("event strobe longer than one cycle");
      fail_count++;
   end

endmodule : button_panel_props

`default_nettype wire

// File: testbench/button_panel_tb.sv
// Testbench for the button panel with bouncing presses and a credit consumer.
// A reference model predicts each event and a checker compares the DUT output.
`timescale 1ns/10ps
`default_nettype none

module button_panel_tb;

   import button_pkg::*;

   typedef enum {PRESS_UP, PRESS_DOWN, PRESS_BOTH} press_kind_t;
   typedef enum {CLEAN, BOUNCE, HELD} press_style_t;

   logic                   clk_25MHz;
   logic                   reset;
   logic                   btn_up;
   logic                   btn_down;
   logic                   credit;
   logic                   evt_valid;
   step_op_t               evt_op;
   logic [COUNT_WIDTH-1:0] evt_count;

   // model state and the queue of events still to come.
   logic [COUNT_WIDTH-1:0] model_count = '0;
   int                     model_credits = CREDIT_MAX;
   step_op_t               exp_op_q[$];
   logic [COUNT_WIDTH-1:0] exp_count_q[$];
   int                     exp_cycle_q[$];

   int          cycle_cnt = 0;
   int          owed = 0;
   int          credit_delay = 1;
   logic        hold_credits = 1'b0;
   int          error_count = 0;
   // all the presses that the main sequence makes.
   int unsigned planned_presses = 272;

   clock_gen clock_gen_i (
      .o_clk_25MHz (clk_25MHz),
      .o_reset     (reset)
   );

   button_panel_top button_panel_top_i (
      .i_clk_25MHz (clk_25MHz),
      .i_reset     (reset),
      .i_btn_up    (btn_up),
      .i_btn_down  (btn_down),
      .i_credit    (credit),
      .o_evt_valid (evt_valid),
      .o_evt_op    (evt_op),
      .o_evt_count (evt_count)
   );

   bind step_counter button_panel_props props_i (
      .i_clk_25MHz (i_clk_25MHz),
      .i_reset     (i_reset),
      .i_evt_valid (o_evt_valid),
      .i_credits   (credits)
   );

   task automatic end_with_failure();
      error_count++;
      $display("SIMULATION FAILED");
      $fatal(1, "run stopped at the first error");
   endtask

   task automatic report_failure(input string msg);
      $display("ERROR at %0t ns: %s", $time, msg);
      end_with_failure();
   endtask

   task automatic check_op(input step_op_t got, input step_op_t exp, input string what);
      if (got !== exp) begin
         $display("CHECK FAILED at %0t ns: %s is %s, expected %s",
                  $time, what, got.name(), exp.name());
         end_with_failure();
      end
   endtask

   task automatic check_count(input logic [COUNT_WIDTH-1:0] got,
                              input logic [COUNT_WIDTH-1:0] exp, input string what);
      if (got !== exp) begin
         $display("CHECK FAILED at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
         end_with_failure();
      end
   endtask

   task automatic check_cycle(input int got, input int exp, input string what);
      if (got != exp) begin
         $display("CHECK FAILED at %0t ns: %s is cycle %0d, expected cycle %0d",
                  $time, what, got, exp);
         end_with_failure();
      end
   endtask

   // Reference model of one press with the cancel, credit and limit rules.
   function automatic logic predict_step(input logic [COUNT_WIDTH-1:0] count,
                                         input int credits, input press_kind_t kind,
                                         output step_op_t op,
                                         output logic [COUNT_WIDTH-1:0] next_count);
      logic ok;
      ok = 1'b0;
      op = STEP_UP;
      next_count = count;
      if (kind == PRESS_UP && credits > 0 && count != COUNT_MAX) begin
         ok = 1'b1;
         next_count = count + 1'b1;
      end
      else if (kind == PRESS_DOWN && credits > 0 && count != 0) begin
         ok = 1'b1;
         op = STEP_DOWN;
         next_count = count - 1'b1;
      end
      return ok;
   endfunction

   task automatic step_cycles(input int n);
      repeat (n) @(posedge clk_25MHz);
      #2;
   endtask

   task automatic drive_buttons(input press_kind_t kind, input logic level);
      if (kind != PRESS_DOWN) begin
         btn_up = level;
      end
      if (kind != PRESS_UP) begin
         btn_down = level;
      end
   endtask

   // A clean raw edge reaches the event output four cycles later.
   task automatic note_press(input press_kind_t kind);
      step_op_t               op;
      logic [COUNT_WIDTH-1:0] next_count;
      if (predict_step(model_count, model_credits, kind, op, next_count)) begin
         exp_op_q.push_back(op);
         exp_count_q.push_back(next_count);
         exp_cycle_q.push_back(cycle_cnt + 4);
         model_count = next_count;
         model_credits--;
      end
   endtask

   task automatic expect_idle();
      if (exp_op_q.size() != 0) begin
         report_failure("an expected step event never appeared");
      end
      check_count(evt_count, model_count, "count at idle");
   endtask

   task automatic do_press(input press_kind_t kind, input press_style_t style);
      int burst_len;
      int hold_len;
      int i;
      while (!hold_credits && owed != 0) begin
         step_cycles(1);
      end
      note_press(kind);
      drive_buttons(kind, 1'b1);
      hold_len = 5;
      if (style == BOUNCE) begin
         // The contact chatters but settles well inside the lockout.
         burst_len = $urandom_range(HOLD_CYCLES - 10, 5);
         for (i = 0; i < burst_len; i++) begin
            step_cycles(1);
            drive_buttons(kind, 1'($urandom_range(1, 0)));
         end
         step_cycles(1);
         drive_buttons(kind, 1'b1);
         hold_len = 2;
      end
      else if (style == HELD) begin
         hold_len = 2 * HOLD_CYCLES;
      end
      step_cycles(hold_len);
      drive_buttons(kind, 1'b0);
      step_cycles(HOLD_CYCLES + 10);
      expect_idle();
   endtask

   always @(posedge clk_25MHz) begin
      cycle_cnt <= cycle_cnt + 1;
   end

   // Checker. Each strobe must match the oldest expected event.
   always @(negedge clk_25MHz) begin
      if (!reset && evt_valid === 1'b1) begin
         if (exp_op_q.size() == 0) begin
            report_failure("step event appeared when none was expected");
         end
         else begin
            check_op(evt_op, exp_op_q.pop_front(), "event opcode");
            check_count(evt_count, exp_count_q.pop_front(), "event count");
            check_cycle(cycle_cnt, exp_cycle_q.pop_front(), "event time");
            owed++;
         end
      end
   end

   // A failed property in the bound checker also ends the run.
   always @(negedge clk_25MHz) begin
      if (button_panel_top_i.step_counter_i.props_i.fail_count != 0) begin
         report_failure("a property of the step counter's credit channel failed");
      end
   end

   // consumer. Returns one credit per received event after a random delay.
   always @(posedge clk_25MHz) begin
      #2;
      credit = 1'b0;
      if (!reset && !hold_credits && owed > 0) begin
         if (credit_delay == 0) begin
            credit = 1'b1;
            owed--;
            model_credits++;
            credit_delay = $urandom_range(8, 1);
         end
         else begin
            credit_delay--;
         end
      end
   end

   initial begin
      int unsigned timeout_cycles;
      timeout_cycles = planned_presses * (HOLD_CYCLES + 20) + 2000;
      repeat (timeout_cycles) @(posedge clk_25MHz);
      report_failure("watchdog timeout, the test sequence did not finish");
   end

   initial begin
      btn_up = 1'b0;
      btn_down = 1'b0;
      credit = 1'b0;
      void'($urandom(32'h41c20a3d));
      wait (!reset);
      step_cycles(2);
      if (evt_valid !== 1'b0) begin
         report_failure("event strobe is not low after reset");
      end
      check_count(evt_count, '0, "count after reset");

      do_press(PRESS_DOWN, CLEAN);
      do_press(PRESS_UP, CLEAN);
      do_press(PRESS_UP, CLEAN);
      do_press(PRESS_DOWN, CLEAN);

      do_press(PRESS_UP, BOUNCE);
      do_press(PRESS_UP, BOUNCE);
      do_press(PRESS_DOWN, HELD);
      do_press(PRESS_UP, HELD);

      do_press(PRESS_BOTH, CLEAN);

      // Withhold credits so that only CREDIT_MAX of six presses get through.
      while (owed != 0) begin
         step_cycles(1);
      end
      hold_credits = 1'b1;
      repeat (6) begin
         do_press(PRESS_UP, CLEAN);
      end
      if (owed != CREDIT_MAX) begin
         report_failure("wrong number of events sent while credits were withheld");
      end
      hold_credits = 1'b0;
      do_press(PRESS_UP, CLEAN);

      repeat (256) begin
         do_press(PRESS_UP, CLEAN);
      end
      check_count(evt_count, COUNT_WIDTH'(COUNT_MAX), "saturated count");

      step_cycles(20);
      if (error_count == 0) begin
         $display("SIMULATION PASSED");
      end
      else begin
         $display("SIMULATION FAILED");
      end
      $finish;
   end

endmodule : button_panel_tb

`default_nettype wire

// File: button_panel.f
design/button_pkg.sv
design/hold_timer.sv
design/edge_debouncer.sv
design/step_counter.sv
design/button_panel_top.sv
testbench/clock_gen.sv
testbench/button_panel_props.sv
testbench/button_panel_tb.sv

// File: Bender.yml
package:
  name: button_panel

sources:
  - files:
      - design/button_pkg.sv
      - design/hold_timer.sv
      - design/edge_debouncer.sv
      - design/step_counter.sv
      - design/button_panel_top.sv
  - target: test
    files:
      - testbench/clock_gen.sv
      - testbench/button_panel_props.sv
      - testbench/button_panel_tb.sv
